// ==== design/cpu_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core-wide sizing for the register CPU
// Data path, program store, RAM and instruction widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Width of one data byte on the buses
`define CPU_DATA_W 8

// Program store address width, 256 instructions
`define CPU_PADDR_W 8

// RAM address width, addressed by the MAR
`define CPU_DADDR_W 8

// General registers a to d
`define CPU_NREGS 4

// Wide instruction word
`define CPU_INST_W 24

`endif

// ==== design/cpu_isa_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set types
// Data and address words, instruction layout, device selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "cpu_settings.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_PADDR_W-1:0] paddr_t;

    // Pass right has no flag effect, everything else sets C and Z
    typedef enum logic [3:0] {alu_pass_r, alu_add, alu_adc, alu_sub,
                              alu_and, alu_or, alu_xor, alu_shl} alu_op_e;

    // Left bus sources, low two bits double as the register index
    typedef enum logic [2:0] {ldev_rega, ldev_regb, ldev_regc, ldev_regd, ldev_mar} ldev_e;

    // Right bus sources, immed comes from the instruction itself
    typedef enum logic [2:0] {rdev_rega, rdev_regb, rdev_regc, rdev_regd,
                              rdev_mar, rdev_ram, rdev_immed} rdev_e;

    // Write targets of the ALU result
    typedef enum logic [3:0] {targ_rega, targ_regb, targ_regc, targ_regd,
                              targ_mar, targ_ram, targ_pc, targ_out, targ_none} targ_e;

    // Execution condition tested against the stored flags
    typedef enum logic [1:0] {cond_always, cond_carry, cond_zero, cond_nzero} cond_e;

    // Instruction fields from the top bit down
    typedef struct packed {
        alu_op_e op;
        targ_e   targ;
        ldev_e   ldev;
        rdev_e   rdev;
        cond_e   cond;
        data_t   immed;
    } inst_t;

endpackage

`default_nettype wire

// ==== design/cpu_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Micro-control types
// Instruction phase and the ALU flag vector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_ctrl_pkg;

    // Idle while stopped, then three phases per instruction
    typedef enum logic [1:0] {phase_idle, phase_fetch, phase_decode, phase_exec} phase_e;

    // Carry in the top bit, zero in the bottom bit
    typedef logic [1:0] flags_t;

    // Bit positions inside flags_t
    localparam int flag_c_bit = 1;
    localparam int flag_z_bit = 0;

endpackage

`default_nettype wire

// ==== design/cpu_ctrl_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded control bundle
// Driven by the controller, read by the datapath blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface cpu_ctrl_if;

    // Current instruction phase
    cpu_ctrl_pkg::phase_e phase;

    // Instruction fields after decode
    cpu_isa_pkg::alu_op_e alu_op;
    cpu_isa_pkg::ldev_e   ldev;
    cpu_isa_pkg::rdev_e   rdev;
    cpu_isa_pkg::targ_e   targ;
    cpu_isa_pkg::data_t   immed;

    // High for the exec cycle of an instruction whose condition holds
    logic commit;

    modport ctrl (output phase, alu_op, ldev, rdev, targ, immed, commit);
    modport alu  (input alu_op, ldev, rdev, immed, commit);
    modport regs (input ldev, rdev, targ, commit);
    modport mem  (input targ, commit);
    modport pc   (input phase, targ, commit);

endinterface

`default_nettype wire

// ==== design/phaser.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction phase sequencer
// Fetch, decode, exec while running, idle otherwise
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module phaser (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  run,
    output cpu_ctrl_pkg::phase_e phase
);

    cpu_ctrl_pkg::phase_e phase_next;

    // Next phase, run low forces idle from any phase
    always_comb begin
        phase_next = cpu_ctrl_pkg::phase_idle;
        if (run) begin
            case (phase)
                cpu_ctrl_pkg::phase_idle:   phase_next = cpu_ctrl_pkg::phase_fetch;
                cpu_ctrl_pkg::phase_fetch:  phase_next = cpu_ctrl_pkg::phase_decode;
                cpu_ctrl_pkg::phase_decode: phase_next = cpu_ctrl_pkg::phase_exec;
                default:                    phase_next = cpu_ctrl_pkg::phase_fetch;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= cpu_ctrl_pkg::phase_idle;
        end else begin
            phase <= phase_next;
        end
    end

    // An instruction never runs into a second exec or a stray decode
    assert property (@(posedge clk) disable iff (!rst_n)
        phase == cpu_ctrl_pkg::phase_exec |=>
            phase inside {cpu_ctrl_pkg::phase_fetch, cpu_ctrl_pkg::phase_idle});

endmodule

`default_nettype wire

// ==== design/program_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter
// Steps once per instruction or loads a jump target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  wire                 clk,
    input  wire                 rst_n,
    cpu_ctrl_if.pc              ctrl,
    input  cpu_isa_pkg::data_t  alu_result,
    output cpu_isa_pkg::paddr_t pc
);

    logic jump;

    // Jump only when the controller commits a pc target
    assign jump = ctrl.commit && (ctrl.targ == cpu_isa_pkg::targ_pc);

    // Update at the end of exec, whether or not the condition held
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (ctrl.phase == cpu_ctrl_pkg::phase_exec) begin
            if (jump) begin
                pc <= alu_result;
            end else begin
                pc <= pc + cpu_isa_pkg::paddr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/wide_controller.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wide-word controller
// Program store, instruction register, field decode
// and condition check that forms commit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module wide_controller (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      prog_we,
    input  cpu_isa_pkg::paddr_t      prog_addr,
    input  wire [`CPU_INST_W-1:0]    prog_data,
    input  cpu_ctrl_pkg::phase_e     phase,
    input  cpu_isa_pkg::paddr_t      pc,
    input  cpu_ctrl_pkg::flags_t     flags,
    cpu_ctrl_if.ctrl                 ctrl
);

    // Program store, one wide word per address
    cpu_isa_pkg::inst_t prog_mem [1 << `CPU_PADDR_W];

    // Instruction register, holds the word through decode and exec
    cpu_isa_pkg::inst_t ir;

    logic cond_met;

    // Load port, only used while the core is stopped
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_data;
        end
    end

    // Latch the word at the PC at the end of fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (phase == cpu_ctrl_pkg::phase_fetch) begin
            ir <= prog_mem[pc];
        end
    end

    // Condition against the stored flags
    always_comb begin
        case (ir.cond)
            cpu_isa_pkg::cond_carry: cond_met = flags[cpu_ctrl_pkg::flag_c_bit];
            cpu_isa_pkg::cond_zero:  cond_met = flags[cpu_ctrl_pkg::flag_z_bit];
            cpu_isa_pkg::cond_nzero: cond_met = !flags[cpu_ctrl_pkg::flag_z_bit];
            default:                 cond_met = 1'b1;
        endcase
    end

    // Field decode straight off the IR
    assign ctrl.phase  = phase;
    assign ctrl.alu_op = ir.op;
    assign ctrl.ldev   = ir.ldev;
    assign ctrl.rdev   = ir.rdev;
    assign ctrl.targ   = ir.targ;
    assign ctrl.immed  = ir.immed;

    // Single write enable for every target
    assign ctrl.commit = (phase == cpu_ctrl_pkg::phase_exec) && cond_met;

    // Program loads are only legal with the sequencer parked
    assert property (@(posedge clk) disable iff (!rst_n)
        prog_we |-> phase == cpu_ctrl_pkg::phase_idle);

    // A commit always comes one cycle after decode
    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.commit |-> $past(phase) == cpu_ctrl_pkg::phase_decode);

endmodule

`default_nettype wire

// ==== design/alu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with operand buses and flag register
// Left and right bus muxes, function, carry and zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module alu (
    input  wire                  clk,
    input  wire                  rst_n,
    cpu_ctrl_if.alu              ctrl,
    input  cpu_isa_pkg::data_t   rd_l_data,
    input  cpu_isa_pkg::data_t   rd_r_data,
    input  cpu_isa_pkg::data_t   mar,
    input  cpu_isa_pkg::data_t   ram_rdata,
    output cpu_isa_pkg::data_t   alu_result,
    output cpu_ctrl_pkg::flags_t flags
);

    cpu_isa_pkg::data_t     lbus;
    cpu_isa_pkg::data_t     rbus;
    logic [`CPU_DATA_W:0]   wide;
    logic                   carry;
    logic                   carry_in;

    // Left bus, any register or the MAR
    assign lbus = (ctrl.ldev == cpu_isa_pkg::ldev_mar) ? mar : rd_l_data;

    // Right bus, registers, MAR, RAM or the immediate
    always_comb begin
        case (ctrl.rdev)
            cpu_isa_pkg::rdev_mar:   rbus = mar;
            cpu_isa_pkg::rdev_ram:   rbus = ram_rdata;
            cpu_isa_pkg::rdev_immed: rbus = ctrl.immed;
            default:                 rbus = rd_r_data;
        endcase
    end

    assign carry_in = flags[cpu_ctrl_pkg::flag_c_bit];

    // 9-bit result, top bit is the carry out
    always_comb begin
        case (ctrl.alu_op)
            cpu_isa_pkg::alu_add: wide = {1'b0, lbus} + {1'b0, rbus};
            cpu_isa_pkg::alu_adc: wide = {1'b0, lbus} + {1'b0, rbus} + {{`CPU_DATA_W{1'b0}}, carry_in};
            // Top bit is the borrow here
            cpu_isa_pkg::alu_sub: wide = {1'b0, lbus} - {1'b0, rbus};
            cpu_isa_pkg::alu_and: wide = {1'b0, lbus & rbus};
            cpu_isa_pkg::alu_or:  wide = {1'b0, lbus | rbus};
            cpu_isa_pkg::alu_xor: wide = {1'b0, lbus ^ rbus};
            // Bit shifted out lands in the carry
            cpu_isa_pkg::alu_shl: wide = {lbus, 1'b0};
            default:              wide = {1'b0, rbus};
        endcase
    end

    assign alu_result = wide[`CPU_DATA_W-1:0];

    // Carry means no borrow on subtract
    assign carry = (ctrl.alu_op == cpu_isa_pkg::alu_sub) ? !wide[`CPU_DATA_W] : wide[`CPU_DATA_W];

    // Flags move only on a committed operation other than pass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ctrl.commit && (ctrl.alu_op != cpu_isa_pkg::alu_pass_r)) begin
            flags[cpu_ctrl_pkg::flag_c_bit] <= carry;
            flags[cpu_ctrl_pkg::flag_z_bit] <= (alu_result == '0);
        end
    end

endmodule

`default_nettype wire

// ==== design/sync_register_file.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// General register file
// Four bytes, left and right read ports, one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module sync_register_file (
    input  wire                 clk,
    input  wire                 rst_n,
    cpu_ctrl_if.regs            ctrl,
    input  cpu_isa_pkg::data_t  alu_result,
    output cpu_isa_pkg::data_t  rd_l_data,
    output cpu_isa_pkg::data_t  rd_r_data
);

    localparam int addr_w = $clog2(`CPU_NREGS);

    cpu_isa_pkg::data_t regs [`CPU_NREGS];

    logic [addr_w-1:0] rd_l_addr;
    logic [addr_w-1:0] rd_r_addr;
    logic [addr_w-1:0] wr_addr;
    logic              wr_en;

    // Register devices sit at codes 0..3 in every select field
    assign rd_l_addr = addr_w'(ctrl.ldev);
    assign rd_r_addr = addr_w'(ctrl.rdev);
    assign wr_addr   = addr_w'(ctrl.targ);

    assign wr_en = ctrl.commit && (ctrl.targ inside {cpu_isa_pkg::targ_rega,
        cpu_isa_pkg::targ_regb, cpu_isa_pkg::targ_regc, cpu_isa_pkg::targ_regd});

    // Reads are combinational, mux selects outside decide use
    assign rd_l_data = regs[rd_l_addr];
    assign rd_r_data = regs[rd_r_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= alu_result;
        end
    end

    // Decoded target from the controller must be clean when committing
    assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.commit |-> !$isunknown(ctrl.targ));

endmodule

`default_nettype wire

// ==== design/memory_io.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and output block
// MAR, RAM addressed by the MAR, output strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module memory_io (
    input  wire                 clk,
    input  wire                 rst_n,
    cpu_ctrl_if.mem             ctrl,
    input  cpu_isa_pkg::data_t  alu_result,
    output cpu_isa_pkg::data_t  mar,
    output cpu_isa_pkg::data_t  ram_rdata,
    output logic                out_valid,
    output cpu_isa_pkg::data_t  out_data
);

    cpu_isa_pkg::data_t ram [1 << `CPU_DADDR_W];

    logic [`CPU_DADDR_W-1:0] ram_addr;

    // Register addressing only, MAR is the whole address
    assign ram_addr  = mar[`CPU_DADDR_W-1:0];
    assign ram_rdata = ram[ram_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.commit && (ctrl.targ == cpu_isa_pkg::targ_mar)) begin
            mar <= alu_result;
        end
    end

    // RAM write at the current MAR
    always_ff @(posedge clk) begin
        if (ctrl.commit && (ctrl.targ == cpu_isa_pkg::targ_ram)) begin
            ram[ram_addr] <= alu_result;
        end
    end

    // One-cycle strobe, data held until the next out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= ctrl.commit && (ctrl.targ == cpu_isa_pkg::targ_out);
            if (ctrl.commit && (ctrl.targ == cpu_isa_pkg::targ_out)) begin
                out_data <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register CPU top level
// Sequencer, controller and datapath blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   run,
    input  wire                   prog_we,
    input  cpu_isa_pkg::paddr_t   prog_addr,
    input  wire [`CPU_INST_W-1:0] prog_data,
    output logic                  out_valid,
    output cpu_isa_pkg::data_t    out_data
);

    cpu_ctrl_pkg::phase_e phase;
    cpu_ctrl_pkg::flags_t flags;
    cpu_isa_pkg::paddr_t  pc;
    cpu_isa_pkg::data_t   alu_result;
    cpu_isa_pkg::data_t   rd_l_data;
    cpu_isa_pkg::data_t   rd_r_data;
    cpu_isa_pkg::data_t   mar;
    cpu_isa_pkg::data_t   ram_rdata;

    // Decoded control shared by every datapath block
    cpu_ctrl_if ctrl_bus ();

    phaser phaser_i (.clk, .rst_n, .run, .phase);

    wide_controller ctrl_i (
        .clk, .rst_n,
        .prog_we, .prog_addr, .prog_data,
        .phase, .pc, .flags,
        .ctrl(ctrl_bus.ctrl)
    );

    program_counter pc_i (.clk, .rst_n, .ctrl(ctrl_bus.pc), .alu_result, .pc);

    alu alu_i (
        .clk, .rst_n, .ctrl(ctrl_bus.alu),
        .rd_l_data, .rd_r_data, .mar, .ram_rdata,
        .alu_result, .flags
    );

    sync_register_file regs_i (
        .clk, .rst_n, .ctrl(ctrl_bus.regs),
        .alu_result, .rd_l_data, .rd_r_data
    );

    memory_io mem_i (
        .clk, .rst_n, .ctrl(ctrl_bus.mem),
        .alu_result, .mar, .ram_rdata,
        .out_valid, .out_data
    );

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the register CPU
// Assembles small programs, predicts the output port
// with an ISA model and checks it with assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   run;
    logic                   prog_we;
    cpu_isa_pkg::paddr_t    prog_addr;
    logic [`CPU_INST_W-1:0] prog_data;
    logic                   out_valid;
    cpu_isa_pkg::data_t     out_data;

    // Program image being assembled
    logic [`CPU_INST_W-1:0] prog [1 << `CPU_PADDR_W];
    int                     prog_len;

    // Expected outputs, head and count as seen by the assertion
    cpu_isa_pkg::data_t exp_q [$];
    cpu_isa_pkg::data_t exp_head;
    int                 exp_left;
    int                 seen;

    string       test_name = "reset";
    int          errors = 0;
    int          checked = 0;
    int          model_steps;
    int          cycles = 0;
    int          deadline = 64;
    logic [31:0] rng_state = 32'ha24d;

    cpu cpu_i (.clk, .rst_n, .run, .prog_we, .prog_addr, .prog_data, .out_valid, .out_data);

    // 100 ns clock
    always #50 clk = ~clk;

    // Fixed-seed byte source for operands
    function automatic cpu_isa_pkg::data_t rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    // Fields from the top: op 4, targ 4, ldev 3, rdev 3, cond 2, immediate 8
    function automatic logic [`CPU_INST_W-1:0] pack_inst(cpu_isa_pkg::alu_op_e op,
            cpu_isa_pkg::targ_e tg, cpu_isa_pkg::ldev_e ld, cpu_isa_pkg::rdev_e rd,
            cpu_isa_pkg::cond_e cd, cpu_isa_pkg::data_t imm);
        return {op, tg, ld, rd, cd, imm};
    endfunction

    task automatic emit(input logic [`CPU_INST_W-1:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    // Pass an immediate to a target, optionally under a condition
    task automatic load_imm(input cpu_isa_pkg::targ_e tg, input cpu_isa_pkg::data_t imm,
            input cpu_isa_pkg::cond_e cd = cpu_isa_pkg::cond_always);
        emit(pack_inst(cpu_isa_pkg::alu_pass_r, tg, cpu_isa_pkg::ldev_rega,
                       cpu_isa_pkg::rdev_immed, cd, imm));
    endtask

    // Right bus source straight to the output port
    task automatic emit_out(input cpu_isa_pkg::rdev_e rd);
        emit(pack_inst(cpu_isa_pkg::alu_pass_r, cpu_isa_pkg::targ_out, cpu_isa_pkg::ldev_rega,
                       rd, cpu_isa_pkg::cond_always, 8'h00));
    endtask

    // Two-operand operation landing in regc
    task automatic emit_alu(input cpu_isa_pkg::alu_op_e op, input cpu_isa_pkg::ldev_e ld,
            input cpu_isa_pkg::rdev_e rd);
        emit(pack_inst(op, cpu_isa_pkg::targ_regc, ld, rd, cpu_isa_pkg::cond_always, 8'h00));
    endtask

    // ISA reference model, runs until the self jump and queues each output
    task automatic model_run();
        cpu_isa_pkg::data_t     mregs [`CPU_NREGS];
        cpu_isa_pkg::data_t     mram [1 << `CPU_DADDR_W];
        cpu_isa_pkg::data_t     mmar;
        cpu_isa_pkg::data_t     lv;
        cpu_isa_pkg::data_t     rv;
        cpu_isa_pkg::data_t     res;
        cpu_isa_pkg::paddr_t    mpc;
        cpu_isa_pkg::paddr_t    next_pc;
        logic [`CPU_INST_W-1:0] w;
        logic                   mc;
        logic                   mz;
        logic                   c;
        logic                   ok;
        logic                   done;
        int                     sum;
        mregs = '{default: '0};
        mram = '{default: '0};
        mmar = '0;
        mpc = '0;
        mc = 1'b0;
        mz = 1'b0;
        done = 1'b0;
        model_steps = 0;
        exp_q.delete();
        while (!done && model_steps < 2000) begin
            w = prog[mpc];
            // Left bus is a register or the MAR
            lv = (w[15:13] == cpu_isa_pkg::ldev_mar) ? mmar : mregs[w[14:13]];
            case (w[12:10])
                cpu_isa_pkg::rdev_mar:   rv = mmar;
                cpu_isa_pkg::rdev_ram:   rv = mram[mmar];
                cpu_isa_pkg::rdev_immed: rv = w[7:0];
                default:                 rv = mregs[w[11:10]];
            endcase
            c = 1'b0;
            case (w[23:20])
                cpu_isa_pkg::alu_add, cpu_isa_pkg::alu_adc: begin
                    sum = int'(lv) + int'(rv);
                    if (w[23:20] == cpu_isa_pkg::alu_adc) begin
                        sum = sum + int'(mc);
                    end
                    res = sum[7:0];
                    c = (sum > 255);
                end
                // Carry set means no borrow
                cpu_isa_pkg::alu_sub: begin
                    res = lv - rv;
                    c = (lv >= rv);
                end
                cpu_isa_pkg::alu_and: res = lv & rv;
                cpu_isa_pkg::alu_or:  res = lv | rv;
                cpu_isa_pkg::alu_xor: res = lv ^ rv;
                cpu_isa_pkg::alu_shl: begin
                    res = {lv[6:0], 1'b0};
                    c = lv[7];
                end
                default: res = rv;
            endcase
            case (w[9:8])
                cpu_isa_pkg::cond_carry: ok = mc;
                cpu_isa_pkg::cond_zero:  ok = mz;
                cpu_isa_pkg::cond_nzero: ok = !mz;
                default:                 ok = 1'b1;
            endcase
            next_pc = mpc + 8'd1;
            if (ok) begin
                // Pass right leaves the flags alone
                if (w[23:20] != cpu_isa_pkg::alu_pass_r) begin
                    mc = c;
                    mz = (res == 8'h00);
                end
                case (w[19:16])
                    cpu_isa_pkg::targ_rega, cpu_isa_pkg::targ_regb,
                    cpu_isa_pkg::targ_regc, cpu_isa_pkg::targ_regd: mregs[w[17:16]] = res;
                    cpu_isa_pkg::targ_mar: mmar = res;
                    cpu_isa_pkg::targ_ram: mram[mmar] = res;
                    cpu_isa_pkg::targ_pc:  next_pc = res;
                    cpu_isa_pkg::targ_out: exp_q.push_back(res);
                    default: begin
                    end
                endcase
            end
            model_steps++;
            done = (next_pc == mpc);
            mpc = next_pc;
        end
    endtask

    // Close the program with a self jump, predict, load and run it
    task automatic run_program(input string name);
        int expected;
        test_name = name;
        load_imm(cpu_isa_pkg::targ_pc, 8'(prog_len));
        model_run();
        expected = exp_q.size();
        deadline = cycles + 16 + prog_len + 3 * model_steps + 40;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // Program load with the core stopped
        for (int a = 0; a < prog_len; a++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= cpu_isa_pkg::paddr_t'(a);
            prog_data <= prog[a];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        run     <= 1'b1;
        while (seen < expected) begin
            @(posedge clk);
        end
        // A few turns of the self jump, stray outputs would show here
        repeat (12) @(posedge clk);
        run <= 1'b0;
        checked += expected;
        prog_len = 0;
    endtask

    // Random immediates into every register, then out of each
    task automatic test_registers();
        for (int r = 0; r < `CPU_NREGS; r++) begin
            load_imm(cpu_isa_pkg::targ_e'(r), rand_byte());
        end
        for (int r = 0; r < `CPU_NREGS; r++) begin
            emit_out(cpu_isa_pkg::rdev_e'(r));
        end
        run_program("reg_immediate");
    endtask

    task automatic test_alu();
        cpu_isa_pkg::alu_op_e ops [6];
        ops = '{cpu_isa_pkg::alu_add, cpu_isa_pkg::alu_sub, cpu_isa_pkg::alu_and,
                cpu_isa_pkg::alu_or, cpu_isa_pkg::alu_xor, cpu_isa_pkg::alu_shl};
        load_imm(cpu_isa_pkg::targ_rega, rand_byte() | 8'h01);
        load_imm(cpu_isa_pkg::targ_regb, rand_byte());
        load_imm(cpu_isa_pkg::targ_regd, 8'hff);
        // 0xff plus a nonzero byte always carries into the adc
        emit_alu(cpu_isa_pkg::alu_add, cpu_isa_pkg::ldev_regd, cpu_isa_pkg::rdev_rega);
        emit_out(cpu_isa_pkg::rdev_regc);
        emit_alu(cpu_isa_pkg::alu_adc, cpu_isa_pkg::ldev_rega, cpu_isa_pkg::rdev_regb);
        emit_out(cpu_isa_pkg::rdev_regc);
        foreach (ops[i]) begin
            emit_alu(ops[i], cpu_isa_pkg::ldev_rega, cpu_isa_pkg::rdev_regb);
            emit_out(cpu_isa_pkg::rdev_regc);
        end
        run_program("alu_ops");
    endtask

    task automatic test_memory();
        cpu_isa_pkg::data_t base;
        cpu_isa_pkg::data_t addr [4];
        int                 order [4];
        base = rand_byte();
        order = '{2, 0, 3, 1};
        for (int i = 0; i < 4; i++) begin
            // Steps of 67 keep the four addresses apart
            addr[i] = base + 8'(i * 67);
            load_imm(cpu_isa_pkg::targ_mar, addr[i]);
            load_imm(cpu_isa_pkg::targ_ram, rand_byte());
        end
        foreach (order[k]) begin
            load_imm(cpu_isa_pkg::targ_mar, addr[order[k]]);
            emit_out(cpu_isa_pkg::rdev_ram);
        end
        run_program("ram_store_load");
    endtask

    task automatic test_countdown();
        cpu_isa_pkg::data_t count;
        count = 8'd3 + (rand_byte() % 8'd6);
        load_imm(cpu_isa_pkg::targ_rega, count);
        // Loop body starts at address 1
        emit_out(cpu_isa_pkg::rdev_rega);
        emit(pack_inst(cpu_isa_pkg::alu_sub, cpu_isa_pkg::targ_rega, cpu_isa_pkg::ldev_rega,
                       cpu_isa_pkg::rdev_immed, cpu_isa_pkg::cond_always, 8'd1));
        load_imm(cpu_isa_pkg::targ_pc, 8'd1, cpu_isa_pkg::cond_nzero);
        run_program("countdown");
    endtask

    task automatic test_skip();
        cpu_isa_pkg::data_t val;
        val = rand_byte() & 8'h7f;
        load_imm(cpu_isa_pkg::targ_rega, val);
        // Below 0x80 plus one never carries
        emit(pack_inst(cpu_isa_pkg::alu_add, cpu_isa_pkg::targ_regb, cpu_isa_pkg::ldev_rega,
                       cpu_isa_pkg::rdev_immed, cpu_isa_pkg::cond_always, 8'd1));
        load_imm(cpu_isa_pkg::targ_rega, ~val, cpu_isa_pkg::cond_carry);
        emit_out(cpu_isa_pkg::rdev_rega);
        run_program("skipped_write");
    endtask

    // Pops the queue on each strobe, reloads the head while in reset
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_head <= (exp_q.size() > 0) ? exp_q[0] : 8'h00;
            exp_left <= exp_q.size();
            seen     <= 0;
        end else if (out_valid) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            exp_head <= (exp_q.size() > 0) ? exp_q[0] : 8'h00;
            exp_left <= exp_q.size();
            seen     <= seen + 1;
        end
    end

    // Each strobe carries the next value predicted by the model
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (exp_left > 0) && (out_data == exp_head))
    else begin
        errors++;
        if ($sampled(exp_left) > 0) begin
            $display("MISMATCH %s expected %h actual %h", test_name,
                     $sampled(exp_head), $sampled(out_data));
        end else begin
            $display("Output %h in test %s came after all predicted outputs",
                     $sampled(out_data), test_name);
        end
    end

    // Held in reset or stopped, the output port stays quiet
    assert property (@(posedge clk) (!rst_n || !run) |-> !out_valid)
    else begin
        errors++;
        $display("Output strobe while the core was in reset or stopped, test %s", test_name);
    end

    // Each test pushes the deadline out by its own length
    initial begin
        while (cycles <= deadline) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout in test %s, the expected outputs did not arrive", test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        // Inputs start quiet with reset asserted
        rst_n     <= 1'b0;
        run       <= 1'b0;
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        prog_len = 0;
        test_registers();
        test_alu();
        test_memory();
        test_countdown();
        test_skip();
        $display("Run complete: %0d outputs checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_ctrl_if.sv
design/phaser.sv
design/program_counter.sv
design/wide_controller.sv
design/alu.sv
design/sync_register_file.sv
design/memory_io.sv
design/cpu.sv
dv/cpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module cpu_tb -Mdir obj_dir -o cpu_sim -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpu_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation passed"
exit 0
